// File: hdl/simple_sys_pkg.sv
package simple_sys_pkg;

  // Bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int BE_W   = DATA_W / 8;

  // RAM window, 4 kB
  localparam int RAM_WORDS = 1024;
  localparam int RAM_IDX_W = $clog2(RAM_WORDS);
  localparam logic [ADDR_W-1:0] RAM_BASE = 32'h0010_0000;
  localparam logic [ADDR_W-1:0] RAM_MASK = ~(ADDR_W'(RAM_WORDS * BE_W) - 1);

  // Timer window, 1 kB
  localparam int TIMER_OFF_W = 10;
  localparam logic [ADDR_W-1:0] TIMER_BASE = 32'h0003_0000;
  localparam logic [ADDR_W-1:0] TIMER_MASK = ~((ADDR_W'(1) << TIMER_OFF_W) - 1);

  // Timer register byte offsets within the window
  localparam logic [TIMER_OFF_W-1:0] TMR_MTIME_LO = 10'h000;
  localparam logic [TIMER_OFF_W-1:0] TMR_MTIME_HI = 10'h004;
  localparam logic [TIMER_OFF_W-1:0] TMR_CMP_LO   = 10'h008;
  localparam logic [TIMER_OFF_W-1:0] TMR_CMP_HI   = 10'h00C;

  // Device selected by the request in flight
  localparam int DEV_W = 2;
  localparam logic [DEV_W-1:0] DEV_NONE  = 2'd0;
  localparam logic [DEV_W-1:0] DEV_RAM   = 2'd1;
  localparam logic [DEV_W-1:0] DEV_TIMER = 2'd2;

endpackage

// File: hdl/sys_bus.sv
`timescale 1ns/1ps

module sys_bus import simple_sys_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_n_i,

  // Host side
  input  logic              host_req_i,
  input  logic              host_we_i,
  input  logic [BE_W-1:0]   host_be_i,
  input  logic [ADDR_W-1:0] host_addr_i,
  input  logic [DATA_W-1:0] host_wdata_i,
  output logic              host_rvalid_o,
  output logic [DATA_W-1:0] host_rdata_o,
  output logic              host_err_o,

  // Device side
  output logic              ram_req_o,
  output logic              tmr_req_o,
  output logic              dev_we_o,
  output logic [BE_W-1:0]   dev_be_o,
  output logic [ADDR_W-1:0] dev_addr_o,
  output logic [DATA_W-1:0] dev_wdata_o,
  input  logic              ram_rvalid_i,
  input  logic [DATA_W-1:0] ram_rdata_i,
  input  logic              tmr_rvalid_i,
  input  logic [DATA_W-1:0] tmr_rdata_i,
  input  logic              tmr_err_i
);

  logic             ram_hit;
  logic             tmr_hit;
  logic [DEV_W-1:0] dev_sel;
  logic [DEV_W-1:0] dev_q;
  logic             pend_q;

  // Window match on the masked address
  assign ram_hit = (host_addr_i & RAM_MASK) == RAM_BASE;
  assign tmr_hit = (host_addr_i & TIMER_MASK) == TIMER_BASE;

  always_comb begin
    if (ram_hit) begin
      dev_sel = DEV_RAM;
    end else if (tmr_hit) begin
      dev_sel = DEV_TIMER;
    end else begin
      dev_sel = DEV_NONE;
    end
  end

  assign ram_req_o = host_req_i && (dev_sel == DEV_RAM);
  assign tmr_req_o = host_req_i && (dev_sel == DEV_TIMER);

  // Shared request fields, each device only looks at its low address bits
  assign dev_we_o    = host_we_i;
  assign dev_be_o    = host_be_i;
  assign dev_addr_o  = host_addr_i;
  assign dev_wdata_o = host_wdata_i;

  // One request in flight at most, so one stage is enough
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pend_q <= 1'b0;
      dev_q  <= DEV_NONE;
    end else begin
      pend_q <= host_req_i;
      dev_q  <= host_req_i ? dev_sel : DEV_NONE;
    end
  end

  // Response merge
  always_comb begin
    case (dev_q)
      DEV_RAM: begin
        host_rvalid_o = ram_rvalid_i;
        host_rdata_o  = ram_rdata_i;
        host_err_o    = 1'b0;
      end
      DEV_TIMER: begin
        host_rvalid_o = tmr_rvalid_i;
        host_rdata_o  = tmr_rdata_i;
        host_err_o    = tmr_err_i;
      end
      default: begin
        // Unmapped address answers with an error
        host_rvalid_o = pend_q;
        host_rdata_o  = '0;
        host_err_o    = pend_q;
      end
    endcase
  end

endmodule

// File: hdl/sys_ram.sv
`timescale 1ns/1ps

module sys_ram import simple_sys_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              req_i,
  input  logic              we_i,
  input  logic [BE_W-1:0]   be_i,
  input  logic [ADDR_W-1:0] addr_i,
  input  logic [DATA_W-1:0] wdata_i,
  output logic              rvalid_o,
  output logic [DATA_W-1:0] rdata_o
);

  logic [DATA_W-1:0]    mem [RAM_WORDS];
  logic [RAM_IDX_W-1:0] idx;
  logic                 rvalid_q;
  logic [DATA_W-1:0]    rdata_q;

  // Word index sits above the byte offset
  assign idx = addr_i[RAM_IDX_W+1:2];

  // Byte-enabled write
  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      for (int b = 0; b < BE_W; b++) begin
        if (be_i[b]) begin
          mem[idx][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i;
    end
  end

  // Read data holds the old word, writes answer with zero
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_q <= we_i ? '0 : mem[idx];
    end
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;

endmodule

// File: hdl/sys_timer.sv
`timescale 1ns/1ps

module sys_timer import simple_sys_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              req_i,
  input  logic              we_i,
  input  logic [BE_W-1:0]   be_i,
  input  logic [ADDR_W-1:0] addr_i,
  input  logic [DATA_W-1:0] wdata_i,
  output logic              rvalid_o,
  output logic [DATA_W-1:0] rdata_o,
  output logic              err_o,
  output logic              timer_irq_o
);

  logic [63:0]            mtime_q;
  logic [63:0]            mtime_d;
  logic [63:0]            mtimecmp_q;
  logic [63:0]            mtimecmp_d;
  logic [TIMER_OFF_W-1:0] reg_off;
  logic                   off_err;
  logic [DATA_W-1:0]      rd_word;
  logic                   wr;
  logic                   rvalid_q;
  logic                   err_q;
  logic [DATA_W-1:0]      rdata_q;
  logic                   irq_q;

  // Merge write data into a register half under the byte enables
  function automatic logic [DATA_W-1:0] be_merge(
    input logic [DATA_W-1:0] old_val,
    input logic [DATA_W-1:0] new_val,
    input logic [BE_W-1:0]   be
  );
    logic [DATA_W-1:0] res;
    res = old_val;
    for (int b = 0; b < BE_W; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = new_val[8*b +: 8];
      end
    end
    return res;
  endfunction

  // Word-aligned offset inside the 1 kB window
  assign reg_off = {addr_i[TIMER_OFF_W-1:2], 2'b00};
  assign wr      = req_i && we_i;

  always_comb begin
    off_err    = 1'b0;
    rd_word    = '0;
    mtime_d    = mtime_q + 64'd1;
    mtimecmp_d = mtimecmp_q;
    case (reg_off)
      TMR_MTIME_LO: begin
        rd_word = mtime_q[31:0];
        if (wr) begin
          // A write replaces this cycle's increment
          mtime_d = {mtime_q[63:32], be_merge(mtime_q[31:0], wdata_i, be_i)};
        end
      end
      TMR_MTIME_HI: begin
        rd_word = mtime_q[63:32];
        if (wr) begin
          mtime_d = {be_merge(mtime_q[63:32], wdata_i, be_i), mtime_q[31:0]};
        end
      end
      TMR_CMP_LO: begin
        rd_word = mtimecmp_q[31:0];
        if (wr) begin
          mtimecmp_d[31:0] = be_merge(mtimecmp_q[31:0], wdata_i, be_i);
        end
      end
      TMR_CMP_HI: begin
        rd_word = mtimecmp_q[63:32];
        if (wr) begin
          mtimecmp_d[63:32] = be_merge(mtimecmp_q[63:32], wdata_i, be_i);
        end
      end
      default: off_err = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      mtime_q    <= '0;
      mtimecmp_q <= '1;
      rvalid_q   <= 1'b0;
      err_q      <= 1'b0;
      irq_q      <= 1'b0;
    end else begin
      mtime_q    <= mtime_d;
      mtimecmp_q <= mtimecmp_d;
      rvalid_q   <= req_i;
      err_q      <= req_i && off_err;
      irq_q      <= mtime_q >= mtimecmp_q;
    end
  end

  // Read returns the value held in the request cycle
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_q <= (we_i || off_err) ? '0 : rd_word;
    end
  end

  assign rvalid_o    = rvalid_q;
  assign rdata_o     = rdata_q;
  assign err_o       = err_q;
  assign timer_irq_o = irq_q;

endmodule

// File: hdl/simple_sys_top.sv
`timescale 1ns/1ps

module simple_sys_top import simple_sys_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_n_i,

  input  logic              host_req_i,
  input  logic              host_we_i,
  input  logic [BE_W-1:0]   host_be_i,
  input  logic [ADDR_W-1:0] host_addr_i,
  input  logic [DATA_W-1:0] host_wdata_i,
  output logic              host_rvalid_o,
  output logic [DATA_W-1:0] host_rdata_o,
  output logic              host_err_o,

  output logic              timer_irq_o
);

  // Shared request fields
  logic              dev_we;
  logic [BE_W-1:0]   dev_be;
  logic [ADDR_W-1:0] dev_addr;
  logic [DATA_W-1:0] dev_wdata;

  // Per-device strobes and responses
  logic              ram_req;
  logic              ram_rvalid;
  logic [DATA_W-1:0] ram_rdata;
  logic              tmr_req;
  logic              tmr_rvalid;
  logic [DATA_W-1:0] tmr_rdata;
  logic              tmr_err;

  sys_bus u_bus (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .host_req_i    (host_req_i),
    .host_we_i     (host_we_i),
    .host_be_i     (host_be_i),
    .host_addr_i   (host_addr_i),
    .host_wdata_i  (host_wdata_i),
    .host_rvalid_o (host_rvalid_o),
    .host_rdata_o  (host_rdata_o),
    .host_err_o    (host_err_o),
    .ram_req_o     (ram_req),
    .tmr_req_o     (tmr_req),
    .dev_we_o      (dev_we),
    .dev_be_o      (dev_be),
    .dev_addr_o    (dev_addr),
    .dev_wdata_o   (dev_wdata),
    .ram_rvalid_i  (ram_rvalid),
    .ram_rdata_i   (ram_rdata),
    .tmr_rvalid_i  (tmr_rvalid),
    .tmr_rdata_i   (tmr_rdata),
    .tmr_err_i     (tmr_err)
  );

  sys_ram u_ram (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .req_i    (ram_req),
    .we_i     (dev_we),
    .be_i     (dev_be),
    .addr_i   (dev_addr),
    .wdata_i  (dev_wdata),
    .rvalid_o (ram_rvalid),
    .rdata_o  (ram_rdata)
  );

  sys_timer u_timer (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_i       (tmr_req),
    .we_i        (dev_we),
    .be_i        (dev_be),
    .addr_i      (dev_addr),
    .wdata_i     (dev_wdata),
    .rvalid_o    (tmr_rvalid),
    .rdata_o     (tmr_rdata),
    .err_o       (tmr_err),
    .timer_irq_o (timer_irq_o)
  );

endmodule

// File: testbench/tb_simple_sys.sv
`timescale 1ns/1ps

module tb_simple_sys import simple_sys_pkg::*; ();

  localparam int CLK_HALF   = 20;
  localparam int VEC_FIELDS = 7;
  localparam int VEC_MAX    = 64;

  // Operation codes of the vector file
  localparam int OP_WRITE = 1;
  localparam int OP_READ  = 2;
  localparam int OP_IDLE  = 3;
  localparam int OP_IRQ   = 4;
  localparam int OP_DELTA = 5;
  localparam int OP_BURST = 6;

  logic              clk;
  logic              rst_n;
  logic              host_req;
  logic              host_we;
  logic [BE_W-1:0]   host_be;
  logic [ADDR_W-1:0] host_addr;
  logic [DATA_W-1:0] host_wdata;
  logic              host_rvalid;
  logic [DATA_W-1:0] host_rdata;
  logic              host_err;
  logic              timer_irq;

  logic [31:0]       vec [VEC_FIELDS*VEC_MAX];
  logic [DATA_W-1:0] model_mem [RAM_WORDS];
  logic [31:0]       rng_state;
  logic              resp_valid;
  logic [DATA_W-1:0] resp_data;
  logic              resp_err;

  int n_rec      = 0;
  int wd_cycles  = 0;
  int test_errs  = 0;
  int pass_cnt   = 0;
  int fail_cnt   = 0;
  int cur_test   = 0;

  simple_sys_top u_simple_sys_top (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .host_req_i    (host_req),
    .host_we_i     (host_we),
    .host_be_i     (host_be),
    .host_addr_i   (host_addr),
    .host_wdata_i  (host_wdata),
    .host_rvalid_o (host_rvalid),
    .host_rdata_o  (host_rdata),
    .host_err_o    (host_err),
    .timer_irq_o   (timer_irq)
  );

  always #(CLK_HALF) clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [DATA_W-1:0] merge_bytes(
    input logic [DATA_W-1:0] old_word,
    input logic [DATA_W-1:0] new_word,
    input logic [BE_W-1:0]   be
  );
    logic [DATA_W-1:0] w;
    w = old_word;
    for (int b = 0; b < BE_W; b++) begin
      if (be[b]) begin
        w[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return w;
  endfunction

  function automatic bit in_ram(input logic [31:0] addr);
    return (addr >= RAM_BASE) && (addr < RAM_BASE + RAM_WORDS * 4);
  endfunction

  function automatic int ram_word(input logic [31:0] addr);
    return int'((addr - RAM_BASE) >> 2);
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] test %0d %s: got 0x%08h, expected 0x%08h", cur_test, name, got, exp);
      test_errs++;
    end
  endtask

  // Drive on the falling edge, sample after the next rising edge
  task automatic bus_cycle(
    input logic        req,
    input logic        we,
    input logic [3:0]  be,
    input logic [31:0] addr,
    input logic [31:0] wdata
  );
    @(negedge clk);
    host_req   = req;
    host_we    = we;
    host_be    = be;
    host_addr  = addr;
    host_wdata = wdata;
    @(posedge clk);
    #1;
    resp_valid = host_rvalid;
    resp_data  = host_rdata;
    resp_err   = host_err;
  endtask

  task automatic issue(
    input logic        we,
    input logic [3:0]  be,
    input logic [31:0] addr,
    input logic [31:0] wdata
  );
    bus_cycle(1'b1, we, be, addr, wdata);
    if (resp_valid !== 1'b1) begin
      $display("test %0d: no response in the cycle after the request to 0x%08h",
               cur_test, addr);
      test_errs++;
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      bus_cycle(1'b0, 1'b0, 4'h0, 32'h0, 32'h0);
      check_val("host_rvalid_o", 32'(resp_valid), 32'h0);
    end
  endtask

  // RAM writes, RAM reads and timer reads on consecutive cycles
  task automatic run_burst(input int n, input logic [31:0] tmr_addr, input logic [31:0] tmr_exp);
    logic [31:0] a;
    for (int i = 0; i < n; i++) begin
      rng_state = xorshift32(rng_state);
      a = RAM_BASE + 32'h200 + 32'(4 * i);
      issue(1'b1, 4'hF, a, rng_state);
      check_val("host_rdata_o", resp_data, 32'h0);
      check_val("host_err_o", 32'(resp_err), 32'h0);
      model_mem[ram_word(a)] = rng_state;
      issue(1'b0, 4'hF, a, 32'h0);
      check_val("host_rdata_o", resp_data, model_mem[ram_word(a)]);
      check_val("host_err_o", 32'(resp_err), 32'h0);
      issue(1'b0, 4'hF, tmr_addr, 32'h0);
      check_val("host_rdata_o", resp_data, tmr_exp);
      check_val("host_err_o", 32'(resp_err), 32'h0);
    end
  endtask

  task automatic run_record(input int r);
    int          op;
    logic [31:0] addr;
    logic [3:0]  be;
    logic [31:0] wdata;
    logic [31:0] exp_data;
    logic        exp_err;
    logic [31:0] t0;
    op       = int'(vec[r*VEC_FIELDS + 1]);
    addr     = vec[r*VEC_FIELDS + 2];
    be       = vec[r*VEC_FIELDS + 3][3:0];
    wdata    = vec[r*VEC_FIELDS + 4];
    exp_data = vec[r*VEC_FIELDS + 5];
    exp_err  = vec[r*VEC_FIELDS + 6][0];
    case (op)
      OP_WRITE: begin
        issue(1'b1, be, addr, wdata);
        check_val("host_rdata_o", resp_data, exp_data);
        check_val("host_err_o", 32'(resp_err), 32'(exp_err));
        if (in_ram(addr)) begin
          model_mem[ram_word(addr)] = merge_bytes(model_mem[ram_word(addr)], wdata, be);
        end
      end
      OP_READ: begin
        issue(1'b0, be, addr, 32'h0);
        check_val("host_rdata_o", resp_data, exp_data);
        check_val("host_err_o", 32'(resp_err), 32'(exp_err));
        if (in_ram(addr)) begin
          check_val("host_rdata_o vs model", resp_data, model_mem[ram_word(addr)]);
        end
      end
      OP_IDLE: begin
        idle_cycles(int'(wdata));
      end
      OP_IRQ: begin
        check_val("timer_irq_o", 32'(timer_irq), exp_data);
      end
      OP_DELTA: begin
        // Two mtime reads with K idle cycles between them
        issue(1'b0, 4'hF, addr, 32'h0);
        check_val("host_err_o", 32'(resp_err), 32'h0);
        t0 = resp_data;
        idle_cycles(int'(wdata));
        issue(1'b0, 4'hF, addr, 32'h0);
        check_val("host_err_o", 32'(resp_err), 32'h0);
        check_val("mtime low delta", resp_data - t0, exp_data);
      end
      OP_BURST: begin
        run_burst(int'(wdata), addr, exp_data);
      end
      default: begin
        $display("test %0d: unknown operation %0d in vector line %0d", cur_test, op, r);
        test_errs++;
      end
    endcase
  endtask

  task automatic finish_test();
    if (cur_test != 0) begin
      if (test_errs == 0) begin
        $display("Test %0d passed", cur_test);
        pass_cnt++;
      end else begin
        $display("Test %0d failed with %0d errors", cur_test, test_errs);
        fail_cnt++;
      end
    end
    test_errs = 0;
  endtask

  initial begin
    int t;
    int op;
    clk        = 1'b0;
    rst_n      = 1'b0;
    host_req   = 1'b0;
    host_we    = 1'b0;
    host_be    = '0;
    host_addr  = '0;
    host_wdata = '0;
    rng_state  = 32'd31694;
    for (int i = 0; i < VEC_FIELDS * VEC_MAX; i++) begin
      vec[i] = '0;
    end
    for (int i = 0; i < RAM_WORDS; i++) begin
      model_mem[i] = 'x;
    end
    $readmemh("testbench/bus_input.txt", vec);

    // Count vector lines and the cycles they spend
    t = 0;
    while (n_rec < VEC_MAX && vec[n_rec*VEC_FIELDS] != 0) begin
      op = int'(vec[n_rec*VEC_FIELDS + 1]);
      if (op == OP_IDLE) t += int'(vec[n_rec*VEC_FIELDS + 4]);
      if (op == OP_DELTA) t += int'(vec[n_rec*VEC_FIELDS + 4]) + 2;
      if (op == OP_BURST) t += 3 * int'(vec[n_rec*VEC_FIELDS + 4]);
      n_rec++;
    end
    wd_cycles = n_rec + t + 100;
    if (n_rec == 0) begin
      $display("No vectors were loaded from testbench/bus_input.txt");
    end

    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    for (int r = 0; r < n_rec; r++) begin
      t = int'(vec[r*VEC_FIELDS]);
      if (t != cur_test) begin
        finish_test();
        cur_test = t;
      end
      run_record(r);
    end
    idle_cycles(1);
    finish_test();

    $display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && pass_cnt > 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin
    wait (wd_cycles > 0);
    repeat (wd_cycles) @(posedge clk);
    $display("Timeout: the run did not finish within %0d clock cycles", wd_cycles);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

// File: testbench/bus_input.txt
// Columns: test op addr be wdata exp_rdata exp_err (hex)
// op 1 write, 2 read, 3 idle (count in wdata), 4 irq level, 5 mtime delta (K), 6 burst
1 1 00100010 f 11223344 00000000 0
1 2 00100010 f 00000000 11223344 0
1 1 00100010 1 aabbccdd 00000000 0
1 2 00100010 f 00000000 112233dd 0
1 1 00100010 6 55667788 00000000 0
1 2 00100010 f 00000000 116677dd 0
1 1 00100010 8 99000000 00000000 0
1 2 00100010 f 00000000 996677dd 0
1 1 00100ffc f cafef00d 00000000 0
1 2 00100ffc f 00000000 cafef00d 0
2 2 00000000 f 00000000 00000000 1
2 1 00050000 f 12345678 00000000 1
2 2 00050000 f 00000000 00000000 1
2 2 00101000 f 00000000 00000000 1
2 2 00030400 f 00000000 00000000 1
2 2 00100010 f 00000000 996677dd 0
3 1 0003000c f 12345678 00000000 0
3 1 00030008 f 9abcdef0 00000000 0
3 2 0003000c f 00000000 12345678 0
3 2 00030008 f 00000000 9abcdef0 0
3 2 00030010 f 00000000 00000000 1
3 1 00030010 f deadbeef 00000000 1
3 2 00030008 f 00000000 9abcdef0 0
3 1 0003000c 1 000000aa 00000000 0
3 2 0003000c f 00000000 123456aa 0
4 5 00030000 f 00000010 00000011 0
4 5 00030000 f 00000003 00000004 0
5 1 00030004 f 00000000 00000000 0
5 1 00030000 f 00000000 00000000 0
5 1 0003000c f 00000000 00000000 0
5 1 00030008 f 00000040 00000000 0
5 4 00000000 0 00000000 00000000 0
5 3 00000000 0 00000050 00000000 0
5 4 00000000 0 00000000 00000001 0
5 1 00030008 f ffffffff 00000000 0
5 1 0003000c f ffffffff 00000000 0
5 3 00000000 0 00000001 00000000 0
5 4 00000000 0 00000000 00000000 0
6 6 0003000c f 00000008 ffffffff 0
0 0 00000000 0 00000000 00000000 0

// File: filelist.f
hdl/simple_sys_pkg.sv
hdl/sys_bus.sv
hdl/sys_ram.sv
hdl/sys_timer.sv
hdl/simple_sys_top.sv
testbench/tb_simple_sys.sv

// File: Bender.yml
package:
  name: simple_sys

sources:
  - hdl/simple_sys_pkg.sv
  - hdl/sys_bus.sv
  - hdl/sys_ram.sv
  - hdl/sys_timer.sv
  - hdl/simple_sys_top.sv
  - target: test
    files:
      - testbench/tb_simple_sys.sv
